//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ice_bus
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard hw/*.sv dv/*.sv include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+include
hw/ice_bus_pkg.sv
hw/ice_settings_pkg.sv
hw/uart.sv
hw/ice_bus_controller.sv
hw/basics_int.sv
hw/gpio_int.sv
hw/ice_bus.sv
dv/tb_ice_bus.sv

//--- dv/tb_ice_bus.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module tb_ice_bus import ice_bus_pkg::*, ice_settings_pkg::*; ();

	localparam int DIV = `ICE_BAUD_DIV;
	localparam int BYTE_CYCLES = 10 * DIV;
	// Every byte sent and received over all tests, rounded up
	localparam int FRAME_BYTES = 110;
	// Long enough for a started reply byte to finish
	localparam int QUIET_CYCLES = 24 * DIV;
	localparam int REPLY_LIMIT = 12 * BYTE_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * FRAME_BYTES * BYTE_CYCLES + 40 * QUIET_CYCLES;

	// Clock on reset, reset on clk
	logic reset;
	logic clk;
	logic uart_rxd;
	logic uart_txd;
	gpio_vec_t gpio_in;
	gpio_vec_t gpio_out;
	gpio_vec_t gpio_oe;

	// Bytes decoded from uart_txd
	char_t rx_q[$];
	int errors;
	int checks;
	int cycles;
	logic [31:0] lcg_state;
	char_t ev_count;

	// Expected GPIO settings
	gpio_vec_t cur_dir;
	gpio_vec_t cur_lvl;
	gpio_vec_t cur_ie;

	ice_bus dut_i (
		.reset(reset),
		.clk(clk),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	// 100 ns period
	always #50 reset = ~reset;

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		end
	endtask

	function automatic char_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// 8N1, LSB first, DIV cycles per bit
	task automatic send_byte(input char_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge reset);
			uart_rxd <= bits[i];
			repeat (DIV - 1) @(posedge reset);
		end
	endtask

	task automatic send_frame(input char_t addr, input char_t len, input char_t d0,
			input char_t d1, input char_t d2);
		send_byte(addr);
		send_byte(len);
		if (len > 8'd0)
			send_byte(d0);
		if (len > 8'd1)
			send_byte(d1);
		if (len > 8'd2)
			send_byte(d2);
	endtask

	// Mid-bit sampling on the falling clock edge
	task automatic recv_byte(output char_t b, output logic ok);
		char_t shift;
		ok = 1'b1;
		shift = '0;
		b = '0;
		do
			@(negedge reset);
		while (uart_txd !== 1'b0);
		repeat (DIV / 2) @(negedge reset);
		if (uart_txd !== 1'b0) begin
			report_error("start bit on uart_txd ended early");
			ok = 1'b0;
			return;
		end
		for (int i = 0; i < `ICE_CHAR_W; i++) begin
			repeat (DIV) @(negedge reset);
			shift[i] = uart_txd;
		end
		repeat (DIV) @(negedge reset);
		if (uart_txd !== 1'b1) begin
			report_error("stop bit missing on uart_txd");
			ok = 1'b0;
		end
		b = shift;
	endtask

	// Waits for n decoded bytes, 0 on timeout
	task automatic wait_bytes(input int n, output logic ok);
		int waited;
		waited = 0;
		while (rx_q.size() < n && waited < REPLY_LIMIT) begin
			@(negedge reset);
			waited++;
		end
		ok = rx_q.size() >= n;
		if (!ok)
			report_error($sformatf("reply incomplete, got %0d of %0d bytes", rx_q.size(), n));
	endtask

	task automatic expect_reply(input char_t addr, input int len, input char_t d0,
			input char_t d1);
		logic ok;
		wait_bytes(2 + len, ok);
		if (!ok) begin
			rx_q.delete();
			return;
		end
		check_val("reply addr", 32'(addr), 32'(rx_q.pop_front()));
		check_val("reply len", len, 32'(rx_q.pop_front()));
		if (len > 0)
			check_val("reply data0", 32'(d0), 32'(rx_q.pop_front()));
		if (len > 1)
			check_val("reply data1", 32'(d1), 32'(rx_q.pop_front()));
	endtask

	// Nothing more may arrive
	task automatic expect_quiet(input string after);
		repeat (QUIET_CYCLES) @(negedge reset);
		if (rx_q.size() != 0)
			report_error($sformatf("%0d unexpected bytes after %s", rx_q.size(), after));
		rx_q.delete();
	endtask

	task automatic check_pads();
		@(negedge reset);
		check_val("gpio_oe", 32'(cur_dir), 32'(gpio_oe));
		check_val("gpio_out", 32'(cur_lvl), 32'(gpio_out));
	endtask

	task automatic query_version();
		send_frame("V", 8'd0, 8'h00, 8'h00, 8'h00);
		expect_reply("V", 2, `ICE_VER_HI, `ICE_VER_LO);
		expect_quiet("version reply");
	endtask

	// Ack 'o', 0 and then the pads follow
	task automatic write_settings(input gpio_vec_t dir, input gpio_vec_t lvl,
			input gpio_vec_t ie);
		send_frame("o", 8'd3, char_t'(dir), char_t'(lvl), char_t'(ie));
		expect_reply("o", 0, 8'h00, 8'h00);
		cur_dir = dir;
		cur_lvl = lvl;
		cur_ie = ie;
		expect_quiet("settings ack");
		check_pads();
	endtask

	// Event only on an enabled input pin
	task automatic toggle_pin(input int pin);
		gpio_vec_t next_in;
		gpio_vec_t mask;
		mask = gpio_vec_t'(1) << pin;
		next_in = gpio_in ^ mask;
		@(posedge reset);
		gpio_in <= next_in;
		if ((mask & cur_ie & ~cur_dir) != '0) begin
			ev_count = ev_count + 8'd1;
			expect_reply("g", 2, ev_count, char_t'(next_in));
			expect_quiet("gpio event");
		end else begin
			expect_quiet($sformatf("toggle of masked pin %0d", pin));
		end
	endtask

	task automatic check_reset_state();
		@(negedge reset);
		check_val("uart_txd", 32'd1, 32'(uart_txd));
		check_val("gpio_oe", 32'd0, 32'(gpio_oe));
		expect_quiet("reset");
	endtask

	task automatic reject_bad_frames();
		// Unknown address with one data byte
		send_frame("Z", 8'd1, 8'h55, 8'h00, 8'h00);
		expect_reply("N", 0, 8'h00, 8'h00);
		expect_quiet("unknown address");
		check_pads();
		// Settings write one byte short
		send_frame("o", 8'd2, ~char_t'(cur_dir), ~char_t'(cur_lvl), 8'h00);
		expect_reply("N", 0, 8'h00, 8'h00);
		expect_quiet("short settings write");
		check_pads();
	endtask

	task automatic watch_gpio_events();
		// Pins 0 and 2 report, 1 and 3 are plain inputs, 6 is an output
		write_settings(8'hf0, 8'ha0, 8'h45);
		toggle_pin(0);
		toggle_pin(2);
		toggle_pin(0);
		toggle_pin(1);
		toggle_pin(6);
	endtask

	task automatic random_settings_sweep();
		gpio_vec_t dir;
		gpio_vec_t lvl;
		gpio_vec_t ie;
		for (int i = 0; i < 5; i++) begin
			dir = lcg_next();
			lvl = lcg_next();
			ie = lcg_next();
			write_settings(dir, lvl, ie);
			query_version();
		end
	endtask

	// UART monitor
	initial begin
		char_t b;
		logic ok;
		@(negedge clk);
		forever begin
			recv_byte(b, ok);
			if (ok)
				rx_q.push_back(b);
		end
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge reset);
			cycles++;
		end
		$display("ERROR: run exceeded %0d cycles, errors: %0d", TIMEOUT_CYCLES, errors);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b0;
		clk = 1'b1;
		uart_rxd = 1'b1;
		gpio_in = '0;
		lcg_state = 32'd12;
		errors = 0;
		checks = 0;
		ev_count = '0;
		cur_dir = '0;
		cur_lvl = '0;
		cur_ie = '0;
		repeat (10) @(posedge reset);
		clk <= 1'b0;

		check_reset_state();
		query_version();
		write_settings(8'h3c, 8'h24, 8'h00);
		reject_bad_frames();
		watch_gpio_events();
		random_settings_sweep();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- hw/basics_int.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module basics_int import ice_bus_pkg::*, ice_settings_pkg::*; (
	input logic reset,
	input logic clk,
	input ma_bus_t ma,
	output logic sl_request,
	input logic sl_grant,
	output sl_bus_t sl,
	input logic sl_next,
	output gpio_settings_t gpio_cfg
);

	logic fv_q;
	logic frame_start;
	logic frame_end;
	char_t addr_q;
	char_t byte_cnt;
	char_t arg [3];
	logic is_ver;
	logic is_set;
	char_t resp [4];
	logic [1:0] resp_last;
	logic [1:0] idx;

	// Edges of the frame window
	assign frame_start = ma.frame_valid && !fv_q;
	assign frame_end = fv_q && !ma.frame_valid;

	// Settings write needs exactly three bytes
	assign is_ver = addr_q == "V";
	assign is_set = addr_q == "o" && byte_cnt == char_t'(3);

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			fv_q <= 1'b0;
			byte_cnt <= '0;
			sl_request <= 1'b0;
			resp_last <= '0;
			idx <= '0;
			gpio_cfg <= '0;
		end else begin
			fv_q <= ma.frame_valid;
			if (frame_start) begin
				byte_cnt <= '0;
			end else if (ma.data_valid) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			if (frame_end) begin
				// Every frame gets an answer
				sl_request <= 1'b1;
				idx <= '0;
				resp_last <= is_ver ? 2'd3 : 2'd1;
				if (is_set) begin
					gpio_cfg <= '{direction: arg[0], level: arg[1], int_enable: arg[2]};
				end
			end else if (sl_grant && sl_next) begin
				if (idx == resp_last) begin
					sl_request <= 1'b0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge reset) begin
		if (frame_start) begin
			addr_q <= ma.addr;
		end
		// Only the first three bytes matter
		if (ma.data_valid && byte_cnt < char_t'(3)) begin
			arg[byte_cnt[1:0]] <= ma.data;
		end
		if (frame_end) begin
			if (is_ver) begin
				resp[0] <= "V";
				resp[1] <= char_t'(2);
				resp[2] <= `ICE_VER_HI;
				resp[3] <= `ICE_VER_LO;
			end else if (is_set) begin
				resp[0] <= "o";
				resp[1] <= '0;
			end else begin
				// NAK, empty
				resp[0] <= "N";
				resp[1] <= '0;
			end
		end
	end

	assign sl = '{data: resp[idx], tail: idx == resp_last};

endmodule

//--- hw/gpio_int.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module gpio_int import ice_bus_pkg::*, ice_settings_pkg::*; (
	input logic reset,
	input logic clk,
	input gpio_vec_t gpio_in,
	output gpio_vec_t gpio_out,
	output gpio_vec_t gpio_oe,
	input gpio_settings_t gpio_cfg,
	output logic sl_request,
	input logic sl_grant,
	output sl_bus_t sl,
	input logic sl_next
);

	gpio_vec_t in_s1;
	gpio_vec_t in_s2;
	gpio_vec_t in_prev;
	gpio_vec_t change;
	gpio_vec_t smp_q;
	gpio_vec_t sample;
	logic chg_q;
	char_t count;
	logic [1:0] idx;

	// Pads
	assign gpio_out = gpio_cfg.level;
	assign gpio_oe = gpio_cfg.direction;

	// Enabled input pins only
	assign change = (in_s2 ^ in_prev) & gpio_cfg.int_enable & ~gpio_cfg.direction;

	always_ff @(posedge reset) begin
		in_s1 <= gpio_in;
		in_s2 <= in_s1;
		in_prev <= in_s2;
		smp_q <= in_s2;
		// New event, or merge while the sample byte is still ahead
		if (chg_q && (!sl_request || idx != 2'd3)) begin
			sample <= smp_q;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			chg_q <= 1'b0;
			count <= '0;
			sl_request <= 1'b0;
			idx <= '0;
		end else begin
			chg_q <= |change;
			if (chg_q && !sl_request) begin
				sl_request <= 1'b1;
				count <= count + 1'b1;
				idx <= '0;
			end else if (sl_request && sl_grant && sl_next) begin
				if (idx == 2'd3) begin
					sl_request <= 1'b0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	// 'g', length 2, count, sample
	always_comb begin
		case (idx)
			2'd0: sl.data = "g";
			2'd1: sl.data = char_t'(2);
			2'd2: sl.data = count;
			default: sl.data = char_t'(sample);
		endcase
		sl.tail = idx == 2'd3;
	end

endmodule

//--- hw/ice_bus.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module ice_bus import ice_bus_pkg::*, ice_settings_pkg::*; (
	input logic reset,
	input logic clk,
	input logic uart_rxd,
	output logic uart_txd,
	input gpio_vec_t gpio_in,
	output gpio_vec_t gpio_out,
	output gpio_vec_t gpio_oe
);

	// UART side
	char_t rx_char;
	logic rx_valid;
	char_t tx_char;
	logic tx_load;
	logic tx_empty;

	// Master and slave buses
	ma_bus_t ma;
	dev_mask_t sl_request;
	dev_mask_t sl_grant;
	sl_bus_t sl_bus [`ICE_NUM_DEV];
	logic sl_next;

	gpio_settings_t gpio_cfg;

	uart uart_i (
		.reset(reset),
		.clk(clk),
		.rxd(uart_rxd),
		.txd(uart_txd),
		.rx_char(rx_char),
		.rx_valid(rx_valid),
		.tx_char(tx_char),
		.tx_load(tx_load),
		.tx_empty(tx_empty)
	);

	ice_bus_controller #(
		.NUM_DEV(`ICE_NUM_DEV)
	) ctrl_i (
		.reset(reset),
		.clk(clk),
		.rx_char(rx_char),
		.rx_valid(rx_valid),
		.tx_char(tx_char),
		.tx_load(tx_load),
		.tx_empty(tx_empty),
		.ma(ma),
		.sl_request(sl_request),
		.sl_grant(sl_grant),
		.sl_bus(sl_bus),
		.sl_next(sl_next)
	);

	// Device 0, highest priority
	basics_int basics_i (
		.reset(reset),
		.clk(clk),
		.ma(ma),
		.sl_request(sl_request[0]),
		.sl_grant(sl_grant[0]),
		.sl(sl_bus[0]),
		.sl_next(sl_next),
		.gpio_cfg(gpio_cfg)
	);

	// Device 1
	gpio_int gpio_i (
		.reset(reset),
		.clk(clk),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.gpio_cfg(gpio_cfg),
		.sl_request(sl_request[1]),
		.sl_grant(sl_grant[1]),
		.sl(sl_bus[1]),
		.sl_next(sl_next)
	);

endmodule

//--- hw/ice_bus_controller.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module ice_bus_controller import ice_bus_pkg::*; #(
	parameter int NUM_DEV = `ICE_NUM_DEV
) (
	input logic reset,
	input logic clk,
	input char_t rx_char,
	input logic rx_valid,
	output char_t tx_char,
	output logic tx_load,
	input logic tx_empty,
	output ma_bus_t ma,
	input dev_mask_t sl_request,
	output dev_mask_t sl_grant,
	input sl_bus_t sl_bus [NUM_DEV],
	output logic sl_next
);

	typedef enum logic [1:0] {P_ADDR, P_LEN, P_DATA, P_DONE} parse_state_t;
	typedef enum logic [1:0] {A_IDLE, A_SEND, A_HOLD} arb_state_t;

	// Frame parser
	parse_state_t p_state;
	char_t remain;
	char_t addr_q;
	char_t data_q;
	logic data_valid_q;
	logic frame_valid_q;

	// Arbiter and serializer
	arb_state_t a_state;
	dev_mask_t low_req;
	sl_bus_t sel_bus;
	logic load_q;
	logic tail_q;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			p_state <= P_ADDR;
			remain <= '0;
			data_valid_q <= 1'b0;
			frame_valid_q <= 1'b0;
		end else begin
			data_valid_q <= 1'b0;
			case (p_state)
				P_ADDR: begin
					if (rx_valid) begin
						frame_valid_q <= 1'b1;
						p_state <= P_LEN;
					end
				end
				P_LEN: begin
					if (rx_valid) begin
						remain <= rx_char;
						// Empty frame ends on its length byte
						if (rx_char == '0) begin
							frame_valid_q <= 1'b0;
							p_state <= P_ADDR;
						end else begin
							p_state <= P_DATA;
						end
					end
				end
				P_DATA: begin
					if (rx_valid) begin
						data_valid_q <= 1'b1;
						remain <= remain - 1'b1;
						if (remain == char_t'(1)) begin
							p_state <= P_DONE;
						end
					end
				end
				P_DONE: begin
					// One cycle after the last strobe
					frame_valid_q <= 1'b0;
					p_state <= P_ADDR;
				end
				default: p_state <= P_ADDR;
			endcase
		end
	end

	always_ff @(posedge reset) begin
		if (rx_valid && p_state == P_ADDR) begin
			addr_q <= rx_char;
		end
		if (rx_valid && p_state == P_DATA) begin
			data_q <= rx_char;
		end
	end

	assign ma = '{addr: addr_q, data: data_q, data_valid: data_valid_q,
		frame_valid: frame_valid_q};

	// Lowest index wins
	always_comb begin
		low_req = '0;
		for (int i = NUM_DEV - 1; i >= 0; i--) begin
			if (sl_request[i]) begin
				low_req = '0;
				low_req[i] = 1'b1;
			end
		end
	end

	// Granted device's byte
	always_comb begin
		sel_bus = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_grant[i]) begin
				sel_bus = sl_bus[i];
			end
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			a_state <= A_IDLE;
			sl_grant <= '0;
			load_q <= 1'b0;
			tail_q <= 1'b0;
		end else begin
			load_q <= 1'b0;
			case (a_state)
				A_IDLE: begin
					if (|sl_request) begin
						sl_grant <= low_req;
						a_state <= A_SEND;
					end
				end
				A_SEND: begin
					if (tx_empty) begin
						load_q <= 1'b1;
						tail_q <= sel_bus.tail;
						a_state <= A_HOLD;
					end
				end
				A_HOLD: begin
					// Responder steps and UART turns busy here
					if (tail_q) begin
						sl_grant <= '0;
						a_state <= A_IDLE;
					end else begin
						a_state <= A_SEND;
					end
				end
				default: a_state <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge reset) begin
		if (a_state == A_SEND && tx_empty) begin
			tx_char <= sel_bus.data;
		end
	end

	// Same strobe loads the UART and advances the responder
	assign tx_load = load_q;
	assign sl_next = load_q;

	a_grant_onehot: assert property (@(posedge reset) disable iff (clk) $onehot0(sl_grant));

	// Responder keeps its request up until the grant drops
	a_grant_req: assert property (@(posedge reset) disable iff (clk)
		(sl_grant & ~sl_request) == '0);

endmodule

//--- hw/ice_bus_pkg.sv
`include "ice_bus_config.svh"

package ice_bus_pkg;

	// One character on the UART or either bus
	typedef logic [`ICE_CHAR_W-1:0] char_t;

	// One bit per slave-bus requester
	typedef logic [`ICE_NUM_DEV-1:0] dev_mask_t;

	// Master bus, driven by the controller to all responders
	// addr holds for the whole frame
	// data_valid strobes once per data byte
	// frame_valid is high from address to last data byte
	typedef struct packed {
		char_t addr;
		char_t data;
		logic data_valid;
		logic frame_valid;
	} ma_bus_t;

	// Slave bus, one per responder
	// Current response byte, tail marks the last one
	typedef struct packed {
		char_t data;
		logic tail;
	} sl_bus_t;

endpackage

//--- hw/ice_settings_pkg.sv
`include "ice_bus_config.svh"

package ice_settings_pkg;

	// One bit per GPIO pin
	typedef logic [`ICE_GPIO_W-1:0] gpio_vec_t;

	// GPIO settings as written by the host with 'o'
	// direction: 1 drives the pin
	// level: value driven on output pins
	// int_enable: input pins that report changes
	typedef struct packed {
		gpio_vec_t direction;
		gpio_vec_t level;
		gpio_vec_t int_enable;
	} gpio_settings_t;

endpackage

//--- hw/uart.sv
`timescale 1ns/1ps
`include "ice_bus_config.svh"

module uart import ice_bus_pkg::*; (
	input logic reset,
	input logic clk,
	input logic rxd,
	output logic txd,
	output char_t rx_char,
	output logic rx_valid,
	input char_t tx_char,
	input logic tx_load,
	output logic tx_empty
);

	localparam int DIV = `ICE_BAUD_DIV;
	localparam int HALF = DIV / 2;
	localparam int CW = $clog2(DIV + 1);
	localparam int FRAME_BITS = `ICE_CHAR_W + 2;

	typedef logic [CW-1:0] baud_cnt_t;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	// Receiver
	logic [1:0] rx_sync;
	logic rx_s;
	rx_state_t rx_state;
	baud_cnt_t rx_cnt;
	logic [$clog2(`ICE_CHAR_W)-1:0] rx_bits;
	char_t rx_shift;
	logic rx_tick;

	// Transmitter
	logic [FRAME_BITS-1:0] tx_shift;
	logic [$clog2(FRAME_BITS)-1:0] tx_bits;
	baud_cnt_t tx_cnt;
	logic tx_busy;

	assign rx_s = rx_sync[1];
	// Mid-bit sample point
	assign rx_tick = rx_cnt == '0;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			// Line idles high
			rx_sync <= 2'b11;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bits <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_sync <= {rx_sync[0], rxd};
			case (rx_state)
				RX_IDLE: begin
					// Falling edge, wait half a bit
					if (!rx_s) begin
						rx_cnt <= baud_cnt_t'(HALF - 1);
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					if (!rx_tick) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else if (rx_s) begin
						// Glitch, not a start bit
						rx_state <= RX_IDLE;
					end else begin
						rx_cnt <= baud_cnt_t'(DIV - 1);
						rx_bits <= '0;
						rx_state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (!rx_tick) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else begin
						rx_cnt <= baud_cnt_t'(DIV - 1);
						if (rx_bits == $bits(rx_bits)'(`ICE_CHAR_W - 1)) begin
							rx_state <= RX_STOP;
						end else begin
							rx_bits <= rx_bits + 1'b1;
						end
					end
				end
				RX_STOP: begin
					if (!rx_tick) begin
						rx_cnt <= rx_cnt - 1'b1;
					end else begin
						rx_state <= RX_IDLE;
						// Framing error drops the byte
						rx_valid <= rx_s;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge reset) begin
		if (rx_state == RX_DATA && rx_tick) begin
			rx_shift <= {rx_s, rx_shift[`ICE_CHAR_W-1:1]};
		end
		if (rx_state == RX_STOP && rx_tick && rx_s) begin
			rx_char <= rx_shift;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			tx_shift <= '1;
			tx_bits <= '0;
			tx_cnt <= '0;
			tx_busy <= 1'b0;
		end else if (tx_load && !tx_busy) begin
			// Stop, data, start from MSB down
			tx_shift <= {1'b1, tx_char, 1'b0};
			tx_bits <= $bits(tx_bits)'(FRAME_BITS - 1);
			tx_cnt <= baud_cnt_t'(DIV - 1);
			tx_busy <= 1'b1;
		end else if (tx_busy) begin
			if (tx_cnt != '0) begin
				tx_cnt <= tx_cnt - 1'b1;
			end else begin
				tx_cnt <= baud_cnt_t'(DIV - 1);
				// Shift in ones so the line rests high
				tx_shift <= {1'b1, tx_shift[FRAME_BITS-1:1]};
				if (tx_bits == '0) begin
					tx_busy <= 1'b0;
				end else begin
					tx_bits <= tx_bits - 1'b1;
				end
			end
		end
	end

	assign txd = tx_shift[0];
	assign tx_empty = !tx_busy;

	// Controller must wait for the shifter
	a_load_idle: assert property (@(posedge reset) disable iff (clk) tx_load |-> tx_empty);

endmodule

//--- include/ice_bus_config.svh
`ifndef ICE_BUS_CONFIG_SVH
`define ICE_BUS_CONFIG_SVH

// Requesters on the slave bus
// Basics is device 0, GPIO is device 1
`define ICE_NUM_DEV 2

// Clock cycles per UART bit
`define ICE_BAUD_DIV 4

// Number of GPIO pins
`define ICE_GPIO_W 8

// Bits per bus character
`define ICE_CHAR_W 8

// Version bytes returned on 'V'
`define ICE_VER_HI 8'h01
`define ICE_VER_LO 8'h02

`endif
